// ==== rtl/tile_macros.svh ====
// tile constants
// bus widths, RAM depth, SFR select bit and interrupt codes

`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// split bus
`define DATA_W 32
`define ADDR_W 32
`define BE_W 4

// local memory depth in words
`define MEM_WORDS 1024

// address bit that selects the SFR block
`define SFR_BITSEL 20

// interrupt stream
`define IRQ_CODE_W 8
`define EXT_IRQ_CODE 8'h0B

`endif

// ==== rtl/membus_pkg.sv ====
// split memory bus types
// request travels master to slave, read response travels back

`include "tile_macros.svh"

package membus_pkg;

    // request held stable by the master until acked
    typedef struct packed
    {
        logic req;
        logic we;
        logic [`ADDR_W-1:0] addr;
        logic [`BE_W-1:0] be;
        logic [`DATA_W-1:0] wdata;
    } membus_req_t;

    // one-cycle read response pulse
    typedef struct packed
    {
        logic resp;
        logic [`DATA_W-1:0] rdata;
    } membus_resp_t;

endpackage

// ==== rtl/tile_pkg.sv ====
// tile state and register types
// SFR map, arbiter owner and interrupt source encodings

package tile_pkg;

    // SFR word offsets
    typedef enum logic [1:0]
    {
        SFR_CORENUM = 2'd0,
        SFR_MSI     = 2'd1
    } sfr_reg_e;

    // internal bus owner
    typedef enum logic
    {
        OWNER_CPU  = 1'b0,
        OWNER_HOST = 1'b1
    } owner_e;

    // source presented on the irq stream
    typedef enum logic [1:0]
    {
        SRC_NONE = 2'd0,
        SRC_EXT  = 2'd1,
        SRC_MSI  = 2'd2
    } irq_src_e;

endpackage

// ==== rtl/bus_decoder.sv ====
// data-side decoder
// steers one master to RAM or SFR block, one read in flight at a time

`timescale 1ns/1ns

`include "tile_macros.svh"

module bus_decoder
(
    input logic clk_i
    , input logic reset_i

    , input membus_pkg::membus_req_t m_req_i
    , output logic m_ack_o
    , output membus_pkg::membus_resp_t m_resp_o

    , output membus_pkg::membus_req_t ram_req_o
    , input logic ram_ack_i
    , input membus_pkg::membus_resp_t ram_resp_i

    , output membus_pkg::membus_req_t sfr_req_o
    , input logic sfr_ack_i
    , input membus_pkg::membus_resp_t sfr_resp_i
);

    logic sel_sfr;
    logic rd_busy;
    logic rd_sel;
    logic accept;
    logic resp_back;

    assign sel_sfr = m_req_i.addr[`SFR_BITSEL];

    // only the selected target sees the request valid
    always_comb
    begin
        ram_req_o = m_req_i;
        sfr_req_o = m_req_i;
        ram_req_o.req = m_req_i.req && !sel_sfr && !rd_busy;
        sfr_req_o.req = m_req_i.req && sel_sfr && !rd_busy;
    end

    assign m_ack_o = !rd_busy && (sel_sfr ? sfr_ack_i : ram_ack_i);
    assign accept = m_req_i.req && m_ack_o;

    assign resp_back = rd_busy && (rd_sel ? sfr_resp_i.resp : ram_resp_i.resp);

    always_comb
    begin
        m_resp_o = rd_sel ? sfr_resp_i : ram_resp_i;
        m_resp_o.resp = resp_back;
    end

    // outstanding read tracking
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rd_busy <= 1'b0;
            rd_sel <= 1'b0;
        end
        else if (accept && !m_req_i.we)
        begin
            rd_busy <= 1'b1;
            rd_sel <= sel_sfr;
        end
        else if (resp_back)
        begin
            rd_busy <= 1'b0;
        end
    end

    // a target only answers a read it was sent
    a_ram_resp_selected: assert property (@(posedge clk_i) disable iff (reset_i)
        ram_resp_i.resp |-> (rd_busy && !rd_sel));
    a_sfr_resp_selected: assert property (@(posedge clk_i) disable iff (reset_i)
        sfr_resp_i.resp |-> (rd_busy && rd_sel));

endmodule

// ==== rtl/bus_arbiter.sv ====
// two-master arbiter
// round-robin merge of CPU data and host onto the internal bus

`timescale 1ns/1ns

`include "tile_macros.svh"

module bus_arbiter
(
    input logic clk_i
    , input logic reset_i

    , input membus_pkg::membus_req_t cpu_req_i
    , output logic cpu_ack_o
    , output membus_pkg::membus_resp_t cpu_resp_o

    , input membus_pkg::membus_req_t host_req_i
    , output logic host_ack_o
    , output membus_pkg::membus_resp_t host_resp_o

    , output membus_pkg::membus_req_t s_req_o
    , input logic s_ack_i
    , input membus_pkg::membus_resp_t s_resp_i
);

    localparam int DEPTH = 2;

    tile_pkg::owner_e prio_q;
    tile_pkg::owner_e grant;
    tile_pkg::owner_e pend_q [DEPTH];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] pend_cnt;
    logic full;
    logic accept;
    logic push;
    logic pop;

    always_comb
    begin
        if (cpu_req_i.req && host_req_i.req)
            grant = prio_q;
        else if (host_req_i.req)
            grant = tile_pkg::OWNER_HOST;
        else
            grant = tile_pkg::OWNER_CPU;
    end

    assign full = (pend_cnt == 2'(DEPTH));

    // hold everyone off while the read record is full
    always_comb
    begin
        s_req_o = (grant == tile_pkg::OWNER_HOST) ? host_req_i : cpu_req_i;
        s_req_o.req = ((grant == tile_pkg::OWNER_HOST) ? host_req_i.req : cpu_req_i.req)
            && !full;
    end

    assign cpu_ack_o = (grant == tile_pkg::OWNER_CPU) && s_ack_i && !full;
    assign host_ack_o = (grant == tile_pkg::OWNER_HOST) && s_ack_i && !full;

    assign accept = s_req_o.req && s_ack_i;
    assign push = accept && !s_req_o.we;
    assign pop = s_resp_i.resp;

    // response goes to the oldest pending read owner
    always_comb
    begin
        cpu_resp_o = s_resp_i;
        host_resp_o = s_resp_i;
        cpu_resp_o.resp = pop && (pend_q[rd_ptr] == tile_pkg::OWNER_CPU);
        host_resp_o.resp = pop && (pend_q[rd_ptr] == tile_pkg::OWNER_HOST);
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            prio_q <= tile_pkg::OWNER_CPU;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            pend_cnt <= 2'd0;
        end
        else
        begin
            if (accept && cpu_req_i.req && host_req_i.req)
                prio_q <= (grant == tile_pkg::OWNER_CPU) ? tile_pkg::OWNER_HOST
                                                         : tile_pkg::OWNER_CPU;
            if (push)
            begin
                pend_q[wr_ptr] <= grant;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            pend_cnt <= pend_cnt + 2'(push) - 2'(pop);
        end
    end

    // slave must not answer a read we never forwarded
    a_resp_has_owner: assert property (@(posedge clk_i) disable iff (reset_i)
        s_resp_i.resp |-> (pend_cnt != 2'd0));

endmodule

// ==== rtl/dual_port_ram.sv ====
// dual-port word RAM
// byte-enabled writes and registered reads on two independent ports

`timescale 1ns/1ns

`include "tile_macros.svh"

module dual_port_ram
(
    input logic clk_i

    , input membus_pkg::membus_req_t p0_req_i
    , output logic p0_ack_o
    , output membus_pkg::membus_resp_t p0_resp_o

    , input membus_pkg::membus_req_t p1_req_i
    , output logic p1_ack_o
    , output membus_pkg::membus_resp_t p1_resp_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    membus_pkg::membus_req_t req [2];
    logic [IDX_W-1:0] idx [2];
    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic [1:0] rd_valid;
    logic [`DATA_W-1:0] rd_data [2];

    assign req[0] = p0_req_i;
    assign req[1] = p1_req_i;

    // word index above the byte offset
    assign idx[0] = p0_req_i.addr[IDX_W+1:2];
    assign idx[1] = p1_req_i.addr[IDX_W+1:2];

    // never stalls
    assign p0_ack_o = 1'b1;
    assign p1_ack_o = 1'b1;

    always_ff @(posedge clk_i)
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (req[p].req && req[p].we)
            begin
                for (int b = 0; b < `BE_W; b++)
                begin
                    if (req[p].be[b])
                        mem[idx[p]][b*8 +: 8] <= req[p].wdata[b*8 +: 8];
                end
            end
            rd_valid[p] <= req[p].req && !req[p].we;
            if (req[p].req && !req[p].we)
                rd_data[p] <= mem[idx[p]];
        end
    end

    assign p0_resp_o = '{resp: rd_valid[0], rdata: rd_data[0]};
    assign p1_resp_o = '{resp: rd_valid[1], rdata: rd_data[1]};

endmodule

// ==== rtl/sfr_block.sv ====
// special-function registers
// core number readback and MSI trigger register

`timescale 1ns/1ns

`include "tile_macros.svh"

module sfr_block
#(
    parameter int core_num = 0
)
(
    input logic clk_i
    , input logic reset_i

    , input membus_pkg::membus_req_t req_i
    , output logic ack_o
    , output membus_pkg::membus_resp_t resp_o

    , output logic msi_req_o
    , output logic [`IRQ_CODE_W-1:0] msi_code_o
);

    tile_pkg::sfr_reg_e reg_sel;
    logic msi_wr;
    logic rd_valid;
    logic [`DATA_W-1:0] rd_data;
    logic [`IRQ_CODE_W-1:0] msi_code_q;

    assign reg_sel = tile_pkg::sfr_reg_e'(req_i.addr[3:2]);
    assign msi_wr = req_i.req && req_i.we && req_i.be[0] && (reg_sel == tile_pkg::SFR_MSI);

    assign ack_o = 1'b1;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rd_valid <= 1'b0;
            msi_req_o <= 1'b0;
            msi_code_q <= '0;
        end
        else
        begin
            rd_valid <= req_i.req && !req_i.we;
            msi_req_o <= msi_wr;
            if (msi_wr)
                msi_code_q <= req_i.wdata[`IRQ_CODE_W-1:0];
        end
    end

    // unmapped offsets read zero
    always_ff @(posedge clk_i)
    begin
        if (req_i.req && !req_i.we)
        begin
            case (reg_sel)
                tile_pkg::SFR_CORENUM: rd_data <= `DATA_W'(core_num);
                tile_pkg::SFR_MSI: rd_data <= `DATA_W'(msi_code_q);
                default: rd_data <= '0;
            endcase
        end
    end

    assign resp_o = '{resp: rd_valid, rdata: rd_data};
    assign msi_code_o = msi_code_q;

endmodule

// ==== rtl/irq_adapter.sv ====
// interrupt adapter
// external edge and MSI merged into one acknowledged request stream

`timescale 1ns/1ns

`include "tile_macros.svh"

module irq_adapter
(
    input logic clk_i
    , input logic reset_i

    , input logic irq_debounced_i
    , input logic msi_req_i
    , input logic [`IRQ_CODE_W-1:0] msi_code_i

    , output logic irq_req_o
    , output logic [`IRQ_CODE_W-1:0] irq_code_o
    , input logic irq_ack_i
);

    tile_pkg::irq_src_e src_q;
    logic irq_prev;
    logic ext_pending;
    logic msi_pending;
    logic [`IRQ_CODE_W-1:0] msi_code_q;
    logic taken;

    assign irq_req_o = (src_q != tile_pkg::SRC_NONE);
    assign taken = irq_req_o && irq_ack_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            src_q <= tile_pkg::SRC_NONE;
            irq_prev <= 1'b0;
            ext_pending <= 1'b0;
            msi_pending <= 1'b0;
            irq_code_o <= '0;
        end
        else
        begin
            irq_prev <= irq_debounced_i;
            if (taken)
            begin
                src_q <= tile_pkg::SRC_NONE;
                if (src_q == tile_pkg::SRC_MSI)
                    msi_pending <= 1'b0;
                else
                    ext_pending <= 1'b0;
            end
            else if (!irq_req_o && msi_pending)
            begin
                // MSI wins over a pending external edge
                src_q <= tile_pkg::SRC_MSI;
                irq_code_o <= msi_code_q;
            end
            else if (!irq_req_o && ext_pending)
            begin
                src_q <= tile_pkg::SRC_EXT;
                irq_code_o <= `EXT_IRQ_CODE;
            end
            // new events override a clear in the same cycle
            if (irq_debounced_i && !irq_prev)
                ext_pending <= 1'b1;
            if (msi_req_i)
            begin
                msi_pending <= 1'b1;
                msi_code_q <= msi_code_i;
            end
        end
    end

    a_code_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (irq_req_o && !irq_ack_i) |=> (irq_req_o && $stable(irq_code_o)));

endmodule

// ==== rtl/sigma_tile.sv ====
// processor tile fabric
// dual-port RAM, SFR block, data arbiter/decoder and interrupt adapter

`timescale 1ns/1ns

`include "tile_macros.svh"

module sigma_tile
#(
    parameter int core_num = 0
)
(
    input logic clk_i
    , input logic reset_i

    , input logic irq_debounced_i

    , input membus_pkg::membus_req_t instr_req_i
    , output logic instr_ack_o
    , output membus_pkg::membus_resp_t instr_resp_o

    , input membus_pkg::membus_req_t cpu_req_i
    , output logic cpu_ack_o
    , output membus_pkg::membus_resp_t cpu_resp_o

    , input membus_pkg::membus_req_t host_req_i
    , output logic host_ack_o
    , output membus_pkg::membus_resp_t host_resp_o

    , output logic irq_req_o
    , output logic [`IRQ_CODE_W-1:0] irq_code_o
    , input logic irq_ack_i
);

    membus_pkg::membus_req_t int_req, ram_req, sfr_req;
    membus_pkg::membus_resp_t int_resp, ram_resp, sfr_resp;
    logic int_ack, ram_ack, sfr_ack;
    logic msi_req;
    logic [`IRQ_CODE_W-1:0] msi_code;

    bus_arbiter arb (
        .clk_i(clk_i), .reset_i(reset_i)
        , .cpu_req_i(cpu_req_i), .cpu_ack_o(cpu_ack_o), .cpu_resp_o(cpu_resp_o)
        , .host_req_i(host_req_i), .host_ack_o(host_ack_o), .host_resp_o(host_resp_o)
        , .s_req_o(int_req), .s_ack_i(int_ack), .s_resp_i(int_resp)
    );

    // bit 20 splits RAM from SFR
    bus_decoder dec (
        .clk_i(clk_i), .reset_i(reset_i)
        , .m_req_i(int_req), .m_ack_o(int_ack), .m_resp_o(int_resp)
        , .ram_req_o(ram_req), .ram_ack_i(ram_ack), .ram_resp_i(ram_resp)
        , .sfr_req_o(sfr_req), .sfr_ack_i(sfr_ack), .sfr_resp_i(sfr_resp)
    );

    dual_port_ram ram (
        .clk_i(clk_i)
        , .p0_req_i(instr_req_i), .p0_ack_o(instr_ack_o), .p0_resp_o(instr_resp_o)
        , .p1_req_i(ram_req), .p1_ack_o(ram_ack), .p1_resp_o(ram_resp)
    );

    sfr_block #(.core_num(core_num)) sfr (
        .clk_i(clk_i), .reset_i(reset_i)
        , .req_i(sfr_req), .ack_o(sfr_ack), .resp_o(sfr_resp)
        , .msi_req_o(msi_req), .msi_code_o(msi_code)
    );

    irq_adapter irq (
        .clk_i(clk_i), .reset_i(reset_i)
        , .irq_debounced_i(irq_debounced_i)
        , .msi_req_i(msi_req), .msi_code_i(msi_code)
        , .irq_req_o(irq_req_o), .irq_code_o(irq_code_o), .irq_ack_i(irq_ack_i)
    );

endmodule

// ==== sim/tb_sigma_tile.sv ====
// testbench for the processor tile fabric
// plays CPU, host and interrupt controller from a trace file

`timescale 1ns/1ns

`include "tile_macros.svh"

module tb_sigma_tile;

    localparam int TIMEOUT = 100;
    localparam int PORT_INSTR = 0;
    localparam int PORT_CPU = 1;
    localparam int PORT_HOST = 2;

    logic clk;
    logic reset_i;
    logic irq_debounced_i;
    logic irq_ack_i;
    logic irq_req_o;
    logic [`IRQ_CODE_W-1:0] irq_code_o;
    membus_pkg::membus_req_t instr_req, cpu_req, host_req;
    membus_pkg::membus_resp_t instr_resp, cpu_resp, host_resp;
    logic instr_ack, cpu_ack, host_ack;

    int errors;
    int tests;
    logic timed_out;
    int fd;
    int r;
    logic done;
    logic [63:0] op;
    logic [31:0] f_we, f_addr, f_be, f_wdata, f_exp;
    logic [8*200-1:0] skip;

    // queued accesses for a simultaneous run
    logic par_we [3];
    logic [31:0] par_addr [3];
    logic [3:0] par_be [3];
    logic [31:0] par_wdata [3];
    logic [31:0] par_exp [3];

    sigma_tile #(.core_num(5)) UUT (
        .clk_i(clk), .reset_i(reset_i), .irq_debounced_i(irq_debounced_i)
        , .instr_req_i(instr_req), .instr_ack_o(instr_ack), .instr_resp_o(instr_resp)
        , .cpu_req_i(cpu_req), .cpu_ack_o(cpu_ack), .cpu_resp_o(cpu_resp)
        , .host_req_i(host_req), .host_ack_o(host_ack), .host_resp_o(host_resp)
        , .irq_req_o(irq_req_o), .irq_code_o(irq_code_o), .irq_ack_i(irq_ack_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error: %s got %h expected %h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic string port_name(input int port);
        case (port)
            PORT_INSTR: return "instr";
            PORT_CPU: return "cpu";
            default: return "host";
        endcase
    endfunction

    function automatic logic port_ack(input int port);
        case (port)
            PORT_INSTR: return instr_ack;
            PORT_CPU: return cpu_ack;
            default: return host_ack;
        endcase
    endfunction

    function automatic membus_pkg::membus_resp_t port_resp(input int port);
        case (port)
            PORT_INSTR: return instr_resp;
            PORT_CPU: return cpu_resp;
            default: return host_resp;
        endcase
    endfunction

    task automatic drive_req(input int port, input membus_pkg::membus_req_t req);
        case (port)
            PORT_INSTR: instr_req <= req;
            PORT_CPU: cpu_req <= req;
            default: host_req <= req;
        endcase
    endtask

    // one request on a master port, then its read response if any
    task automatic bus_access(input int port, input logic is_wr, input logic [31:0] byte_addr,
                              input logic [3:0] byte_en, input logic [31:0] wr_data,
                              input logic [31:0] exp_data);
        membus_pkg::membus_req_t req;
        membus_pkg::membus_resp_t rsp;
        int n;
        logic seen;
        req = '{req: 1'b1, we: is_wr, addr: byte_addr, be: byte_en, wdata: wr_data};
        @(posedge clk);
        drive_req(port, req);
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT)
        begin
            @(negedge clk);
            seen = port_ack(port);
            n++;
        end
        // taken at this edge when ack was high
        @(posedge clk);
        drive_req(port, '0);
        if (!seen)
        begin
            $display("timeout: %s acknowledge never came", port_name(port));
            timed_out = 1'b1;
            errors++;
        end
        else if (!is_wr)
        begin
            n = 0;
            seen = 1'b0;
            while (!seen && n < TIMEOUT)
            begin
                @(negedge clk);
                rsp = port_resp(port);
                seen = rsp.resp;
                n++;
            end
            if (!seen)
            begin
                $display("timeout: %s read response never came", port_name(port));
                timed_out = 1'b1;
                errors++;
            end
            else
                compare_value({port_name(port), "_resp_o.rdata"}, rsp.rdata, exp_data);
        end
    endtask

    task automatic pulse_irq_line();
        @(posedge clk);
        irq_debounced_i <= 1'b1;
        repeat (2) @(posedge clk);
        irq_debounced_i <= 1'b0;
    endtask

    // wait for a request, check its code, ack it and see it drop
    task automatic take_irq(input logic [`IRQ_CODE_W-1:0] exp_code);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq_req_o && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!irq_req_o)
        begin
            $display("timeout: interrupt request never came");
            timed_out = 1'b1;
            errors++;
        end
        else
        begin
            compare_value("irq_code_o", 32'(irq_code_o), 32'(exp_code));
            @(posedge clk);
            irq_ack_i <= 1'b1;
            @(posedge clk);
            irq_ack_i <= 1'b0;
            @(negedge clk);
            compare_value("irq_req_o", 32'(irq_req_o), 32'h0);
        end
    endtask

    task automatic run_op();
        int err_before;
        logic counted;
        err_before = errors;
        counted = 1'b1;
        case (op)
            "instr": bus_access(PORT_INSTR, f_we[0], f_addr, f_be[3:0], f_wdata, f_exp);
            "cpu": bus_access(PORT_CPU, f_we[0], f_addr, f_be[3:0], f_wdata, f_exp);
            "host": bus_access(PORT_HOST, f_we[0], f_addr, f_be[3:0], f_wdata, f_exp);
            "edge":
            begin
                counted = 1'b0;
                pulse_irq_line();
            end
            "irq": take_irq(f_exp[`IRQ_CODE_W-1:0]);
            "pcpu", "phost":
            begin
                counted = 1'b0;
                r = (op == "pcpu") ? PORT_CPU : PORT_HOST;
                par_we[r] = f_we[0];
                par_addr[r] = f_addr;
                par_be[r] = f_be[3:0];
                par_wdata[r] = f_wdata;
                par_exp[r] = f_exp;
            end
            "run":
            begin
                fork
                    bus_access(PORT_CPU, par_we[PORT_CPU], par_addr[PORT_CPU],
                               par_be[PORT_CPU], par_wdata[PORT_CPU], par_exp[PORT_CPU]);
                    bus_access(PORT_HOST, par_we[PORT_HOST], par_addr[PORT_HOST],
                               par_be[PORT_HOST], par_wdata[PORT_HOST], par_exp[PORT_HOST]);
                join
            end
            default:
            begin
                $display("unknown trace operation %0s", op);
                errors++;
            end
        endcase
        if (counted)
        begin
            tests++;
            $display("test %0d %0s: %0s", tests, op, (errors == err_before) ? "ok" : "failed");
        end
    endtask

    initial
    begin
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        reset_i = 1'b1;
        irq_debounced_i = 1'b0;
        irq_ack_i = 1'b0;
        instr_req = '0;
        cpu_req = '0;
        host_req = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        fd = $fopen("sim/tile_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file sim/tile_trace.txt");
            errors++;
        end
        else
        begin
            done = 1'b0;
            while (!done)
            begin
                r = $fscanf(fd, "%s", op);
                if (r != 1)
                    done = 1'b1;
                else if (op == "#")
                    r = $fgets(skip, fd);
                else
                begin
                    r = $fscanf(fd, "%h %h %h %h %h", f_we, f_addr, f_be, f_wdata, f_exp);
                    if (r != 5)
                    begin
                        $display("malformed trace line after test %0d", tests);
                        errors++;
                        done = 1'b1;
                    end
                    else
                    begin
                        run_op();
                        done = timed_out;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/membus_pkg.sv
rtl/tile_pkg.sv
rtl/bus_decoder.sv
rtl/bus_arbiter.sv
rtl/dual_port_ram.sv
rtl/sfr_block.sv
rtl/irq_adapter.sv
rtl/sigma_tile.sv
sim/tb_sigma_tile.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_sigma_tile -f sim.f || exit 1
out=$(./obj_dir/Vtb_sigma_tile)
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/tile_trace.txt ====
# op is instr cpu host edge irq pcpu phost or run, a # token starts a comment line
# op we addr be wdata expect, all hex, unused fields 0, pcpu/phost queue a run
# RAM writes from host, readback from CPU data port
host 1 00000000 f 11223344 0
host 1 00000004 f a5a5a5a5 0
host 1 00000008 f 0badf00d 0
cpu 0 00000000 0 0 11223344
host 1 00000000 3 ffffeeee 0
cpu 0 00000000 0 0 1122eeee
host 1 00000004 c 12340000 0
cpu 0 00000004 0 0 1234a5a5
cpu 1 00000008 2 00007700 0
host 0 00000008 0 0 0bad770d
# instruction port sees the same words
instr 0 00000000 0 0 1122eeee
instr 0 00000004 0 0 1234a5a5
instr 0 00000008 0 0 0bad770d
host 1 00000ffc f cafef00d 0
instr 0 00000ffc 0 0 cafef00d
# SFR block at address bit 20
host 0 00100000 0 0 00000005
cpu 0 00100000 0 0 00000005
host 1 00100004 1 00000042 0
irq 0 0 0 0 42
host 0 00100004 0 0 00000042
# MSI pending together with an external edge
host 1 00100004 f 00000057 0
edge 0 0 0 0 0
irq 0 0 0 0 57
irq 0 0 0 0 0b
edge 0 0 0 0 0
irq 0 0 0 0 0b
host 0 00100004 0 0 00000057
# CPU and host in the same cycles
host 1 00000010 f 10101010 0
cpu 1 00000014 f 20202020 0
pcpu 0 00000010 0 0 10101010
phost 0 00000014 0 0 20202020
run 0 0 0 0 0
pcpu 0 00000014 0 0 20202020
phost 0 00000010 0 0 10101010
run 0 0 0 0 0
pcpu 0 00000008 0 0 0bad770d
phost 0 00100000 0 0 00000005
run 0 0 0 0 0
